/* verilog/vmem_pkg.sv */
package vmem_pkg;

    // lanes per vector micro-op
    localparam int NUM_LANES = 4;

    // data and address word
    typedef logic [31:0] word_t;

    // vector element width
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } veew_t;

    // scalar access kind
    // produced by the coalescer, used for byte enables and load extraction
    typedef enum logic [1:0] {
        LB = 2'd0,
        LH = 2'd1,
        LW = 2'd2
    } load_type_t;

    // one memory word seen as bytes or as halfwords
    // bytes[0] and halves[0] are the least significant parts
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } vmem_word_u;

endpackage

/* verilog/vmem_coalescer.sv */
module vmem_coalescer (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush,
    input  logic                 vmemdren,
    input  logic                 vmemdwen,
    input  logic                 vindexed,
    input  vmem_pkg::word_t      base,
    input  vmem_pkg::word_t      stride,
    input  logic [2:0]           vuop_num,
    input  vmem_pkg::veew_t      veew,
    input  logic [3:0]           vlane_mask,
    input  vmem_pkg::word_t      vlane_addr [vmem_pkg::NUM_LANES],
    input  logic                 mem_ready,
    output logic [1:0]           curr_lane,
    output vmem_pkg::word_t      lane_addr_out,
    output logic                 req_ren,
    output logic                 req_wen,
    output vmem_pkg::load_type_t load_type,
    output logic                 stall
);

    import vmem_pkg::*;

    // lane walker state is the index of the lane being served
    logic [1:0] lane;
    logic [1:0] next_lane;

    // running strided address, carried across micro-ops
    word_t next_addr;
    word_t next_next_addr;

    logic active;
    logic lane_on;
    logic advance;
    logic last_lane;

    // a request is present when either enable is high
    assign active = vmemdren | vmemdwen;

    // mask bit of the lane being served
    assign lane_on = vlane_mask[lane];

    // active lane moves on when accepted, masked lane after one idle cycle
    assign advance = active & (~lane_on | mem_ready);

    assign last_lane = (lane == 2'(NUM_LANES - 1));

    // address of the current element
    always_comb begin
        if (vindexed) begin
            lane_addr_out = vlane_addr[lane];
        end else if ((lane == 2'd0) && (vuop_num == 3'd0)) begin
            // first element of a new instruction
            lane_addr_out = base;
        end else begin
            lane_addr_out = next_addr;
        end
    end

    // next lane and next strided address
    always_comb begin
        next_lane      = lane;
        next_next_addr = next_addr;
        if (advance) begin
            // lane 3 wraps back to lane 0
            next_lane      = lane + 2'd1;
            next_next_addr = lane_addr_out + stride;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            lane      <= 2'd0;
            next_addr <= '0;
        end else if (flush) begin
            lane      <= 2'd0;
            next_addr <= '0;
        end else begin
            lane      <= next_lane;
            next_addr <= next_next_addr;
        end
    end

    assign curr_lane = lane;

    // masked lanes issue nothing
    assign req_ren = vmemdren & lane_on;
    assign req_wen = vmemdwen & lane_on;

    // core is held until the last lane completes
    assign stall = active & ~(last_lane & advance);

    // access size follows the element width
    always_comb begin
        case (veew)
            SEW8:    load_type = LB;
            SEW16:   load_type = LH;
            default: load_type = LW;
        endcase
    end

endmodule

/* verilog/vmem_store_format.sv */
module vmem_store_format (
    input  vmem_pkg::veew_t veew,
    input  vmem_pkg::word_t vlane_store_data [vmem_pkg::NUM_LANES],
    output vmem_pkg::word_t fmt_data         [vmem_pkg::NUM_LANES]
);

    import vmem_pkg::*;

    // the element sits in the low bits of each lane's store word
    // copy it into every slot so any byte enable finds it in place
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            case (veew)
                SEW8: begin
                    // byte in all four positions
                    fmt_data[i] = {4{vlane_store_data[i][7:0]}};
                end
                SEW16: begin
                    // halfword in both halves
                    fmt_data[i] = {2{vlane_store_data[i][15:0]}};
                end
                default: begin
                    fmt_data[i] = vlane_store_data[i];
                end
            endcase
        end
    end

endmodule

/* verilog/vmem_port_combine.sv */
module vmem_port_combine (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush,
    input  logic [1:0]           curr_lane,
    input  vmem_pkg::word_t      lane_addr_out,
    input  logic                 req_ren,
    input  logic                 req_wen,
    input  vmem_pkg::load_type_t load_type,
    input  vmem_pkg::word_t      fmt_data [vmem_pkg::NUM_LANES],
    input  logic                 mem_ready,
    input  vmem_pkg::word_t      mem_rdata,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output vmem_pkg::word_t      mem_wdata,
    output logic [3:0]           mem_be,
    output vmem_pkg::word_t      vload_data [vmem_pkg::NUM_LANES]
);

    import vmem_pkg::*;

    vmem_word_u rword;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       load_word;

    // request enables pass straight to the memory port
    assign mem_ren   = req_ren;
    assign mem_wen   = req_wen;
    assign mem_wdata = fmt_data[curr_lane];

    // byte enables from access size and low address bits
    always_comb begin
        case (load_type)
            LB:      mem_be = 4'b0001 << lane_addr_out[1:0];
            LH:      mem_be = lane_addr_out[1] ? 4'b1100 : 4'b0011;
            default: mem_be = 4'b1111;
        endcase
    end

    // element extraction, natural alignment assumed
    assign rword    = mem_rdata;
    assign byte_sel = rword.bytes[lane_addr_out[1:0]];
    assign half_sel = rword.halves[lane_addr_out[1]];

    always_comb begin
        case (load_type)
            LB:      load_word = {{24{byte_sel[7]}}, byte_sel};
            LH:      load_word = {{16{half_sel[15]}}, half_sel};
            default: load_word = mem_rdata;
        endcase
    end

    // result register of the current lane updates at the accepting edge
    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                vload_data[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                vload_data[i] <= '0;
            end
        end else if (req_ren && mem_ready) begin
            vload_data[curr_lane] <= load_word;
        end
    end

endmodule

/* verilog/vmem_lsu_top.sv */
module vmem_lsu_top (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            flush,
    input  logic            vmemdren,
    input  logic            vmemdwen,
    input  vmem_pkg::word_t base,
    input  vmem_pkg::word_t stride,
    input  logic            vindexed,
    input  logic [2:0]      vuop_num,
    input  vmem_pkg::veew_t veew,
    input  logic [3:0]      vlane_mask,
    input  vmem_pkg::word_t vlane_addr       [vmem_pkg::NUM_LANES],
    input  vmem_pkg::word_t vlane_store_data [vmem_pkg::NUM_LANES],
    output logic            stall,
    output vmem_pkg::word_t vload_data       [vmem_pkg::NUM_LANES],
    output vmem_pkg::word_t mem_addr,
    output logic            mem_ren,
    output logic            mem_wen,
    output vmem_pkg::word_t mem_wdata,
    output logic [3:0]      mem_be,
    input  logic            mem_ready,
    input  vmem_pkg::word_t mem_rdata
);

    import vmem_pkg::*;

    logic [1:0] curr_lane;
    logic       req_ren;
    logic       req_wen;
    load_type_t load_type;
    word_t      fmt_data [NUM_LANES];

    // lane walker, its address goes straight out as mem_addr
    vmem_coalescer vmem_coalescer_inst (
        .CLK           (CLK),
        .nRST          (nRST),
        .flush         (flush),
        .vmemdren      (vmemdren),
        .vmemdwen      (vmemdwen),
        .vindexed      (vindexed),
        .base          (base),
        .stride        (stride),
        .vuop_num      (vuop_num),
        .veew          (veew),
        .vlane_mask    (vlane_mask),
        .vlane_addr    (vlane_addr),
        .mem_ready     (mem_ready),
        .curr_lane     (curr_lane),
        .lane_addr_out (mem_addr),
        .req_ren       (req_ren),
        .req_wen       (req_wen),
        .load_type     (load_type),
        .stall         (stall)
    );

    vmem_store_format vmem_store_format_inst (
        .veew             (veew),
        .vlane_store_data (vlane_store_data),
        .fmt_data         (fmt_data)
    );

    vmem_port_combine vmem_port_combine_inst (
        .CLK           (CLK),
        .nRST          (nRST),
        .flush         (flush),
        .curr_lane     (curr_lane),
        .lane_addr_out (mem_addr),
        .req_ren       (req_ren),
        .req_wen       (req_wen),
        .load_type     (load_type),
        .fmt_data      (fmt_data),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .mem_ren       (mem_ren),
        .mem_wen       (mem_wen),
        .mem_wdata     (mem_wdata),
        .mem_be        (mem_be),
        .vload_data    (vload_data)
    );

endmodule

/* sim/vmem_lsu_assert.sv */
module vmem_lsu_assert (
    input logic            CLK,
    input logic            nRST,
    input logic            vmemdren,
    input logic            vmemdwen,
    input logic            stall,
    input logic            mem_ren,
    input logic            mem_wen,
    input logic [3:0]      mem_be,
    input logic            mem_ready,
    input vmem_pkg::word_t mem_addr,
    input vmem_pkg::veew_t veew
);
    timeunit 1ns;
    timeprecision 100ps;

    import vmem_pkg::*;

    logic       req;
    logic       misaligned;
    logic [2:0] elem_size;

    assign req = mem_ren | mem_wen;

    // natural alignment per element width
    assign misaligned = ((veew == SEW16) && mem_addr[0]) ||
                        ((veew == SEW32) && (mem_addr[1:0] != 2'd0));

    // bytes in one element
    assign elem_size = (veew == SEW8) ? 3'd1 : ((veew == SEW16) ? 3'd2 : 3'd4);

    ren_wen_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("read and write enables high together");

    be_matches_width: assert property (@(posedge CLK) disable iff (!nRST)
        req |-> ($countones(mem_be) == int'(elem_size)))
        else $error("byte enables do not cover exactly one element");

    addr_aligned: assert property (@(posedge CLK) disable iff (!nRST)
        req |-> !misaligned)
        else $error("request address not aligned to the element width");

    // a lane still waiting for memory keeps the core held
    stall_on_backpressure: assert property (@(posedge CLK) disable iff (!nRST)
        (req && !mem_ready) |-> stall)
        else $error("stall low while a request waits for memory");

endmodule

/* sim/vmem_lsu_tb.sv */
module vmem_lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import vmem_pkg::*;

    localparam int NUM_UOPS       = 300;
    localparam int TIMEOUT_CYCLES = NUM_UOPS * NUM_LANES * 5 + 100;

    logic       CLK;
    logic       nRST;
    logic       flush;
    logic       vmemdren;
    logic       vmemdwen;
    logic       vindexed;
    word_t      base;
    word_t      stride;
    logic [2:0] vuop_num;
    veew_t      veew;
    logic [3:0] vlane_mask;
    word_t      vlane_addr       [NUM_LANES];
    word_t      vlane_store_data [NUM_LANES];
    logic       stall;
    word_t      vload_data       [NUM_LANES];
    word_t      mem_addr;
    logic       mem_ren;
    logic       mem_wen;
    word_t      mem_wdata;
    logic [3:0] mem_be;
    logic       mem_ready;
    word_t      mem_rdata;

    // memory model and reference state
    word_t mem [256];
    word_t exp_load [NUM_LANES];
    word_t model_next;
    word_t exp_addr_q [$];
    int    exp_lane_q [$];
    int    cycle_count = 0;

    vmem_lsu_top vmem_lsu_top_inst (.*);

    bind vmem_lsu_top vmem_lsu_assert vmem_lsu_assert_inst (
        .CLK       (CLK),
        .nRST      (nRST),
        .vmemdren  (vmemdren),
        .vmemdwen  (vmemdwen),
        .stall     (stall),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_be    (mem_be),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .veew      (veew)
    );

    // read data follows the address in the same cycle
    assign mem_rdata = mem[mem_addr[9:2]];

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("run did not finish within the cycle limit");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input word_t exp, input word_t got);
        if (exp !== got) begin
            fail_run($sformatf("error %s exp %h got %h", name, exp, got));
        end
    endtask

    function automatic int elem_bytes(veew_t w);
        if (w == SEW8) return 1;
        else if (w == SEW16) return 2;
        return 4;
    endfunction

    // a byte is enabled when it falls in the same element slot as the address
    function automatic logic [3:0] lane_be(word_t addr, int n);
        logic [3:0] be;
        int         off;
        off = 32'(addr[1:0]);
        for (int b = 0; b < 4; b++) begin
            be[b] = ((b / n) == (off / n));
        end
        return be;
    endfunction

    function automatic word_t lane_wdata(word_t d, int n);
        word_t r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = d[8*(b % n) +: 8];
        end
        return r;
    endfunction

    // old word with the element written in at its offset
    function automatic word_t merge_word(word_t old, word_t addr, word_t d, int n);
        word_t      r;
        logic [3:0] be;
        r  = old;
        be = lane_be(addr, n);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) r[8*b +: 8] = d[8*(b % n) +: 8];
        end
        return r;
    endfunction

    function automatic word_t sext_elem(word_t w, word_t addr, int n);
        logic [7:0]  b;
        logic [15:0] h;
        int          off;
        off = 32'(addr[1:0]);
        b   = w[8*off +: 8];
        h   = w[16*(off / 2) +: 16];
        if (n == 1) return {{24{b[7]}}, b};
        else if (n == 2) return {{16{h[15]}}, h};
        return w;
    endfunction

    task automatic check_quiet();
        check("stall", 0, 32'(stall));
        check("mem_ren", 0, 32'(mem_ren));
        check("mem_wen", 0, 32'(mem_wen));
    endtask

    task automatic check_loads();
        for (int i = 0; i < NUM_LANES; i++) begin
            check($sformatf("vload_data[%0d]", i), exp_load[i], vload_data[i]);
        end
    endtask

    // fields held for a whole instruction, base kept away from the array ends
    task automatic new_instruction();
        int n;
        veew     = veew_t'($urandom_range(0, 2));
        n        = elem_bytes(veew);
        vindexed = ($urandom_range(0, 3) == 0);
        base     = $urandom_range(256, 767) & ~32'(n - 1);
        stride   = 32'(($urandom_range(0, 4) - 2) * n);
        vuop_num = 3'd0;
    endtask

    task automatic issue_uop();
        word_t a;
        int    n;
        n          = elem_bytes(veew);
        vmemdren   = 1'($urandom_range(0, 1));
        vmemdwen   = ~vmemdren;
        vlane_mask = 4'($urandom_range(0, 15));
        for (int i = 0; i < NUM_LANES; i++) begin
            vlane_addr[i]       = $urandom_range(0, 1023) & ~32'(n - 1);
            vlane_store_data[i] = $urandom;
        end
        // reference address walk, next address moves on for masked lanes too
        for (int i = 0; i < NUM_LANES; i++) begin
            if (vindexed) a = vlane_addr[i];
            else if (i == 0 && vuop_num == 3'd0) a = base;
            else a = model_next;
            if (vlane_mask[i]) begin
                exp_addr_q.push_back(a);
                exp_lane_q.push_back(i);
            end
            model_next = a + stride;
        end
    endtask

    task automatic run_uop(input int flush_at, output bit flushed);
        bit         done;
        bit         wr_acc;
        int         cyc;
        int         lane;
        int         n;
        word_t      a;
        word_t      wr_old;
        word_t      wr_addr;
        word_t      wr_elem;
        word_t      wr_data;
        logic [3:0] wr_be;
        done    = 1'b0;
        flushed = 1'b0;
        cyc     = 0;
        n       = elem_bytes(veew);
        while (!done && !flushed) begin
            @(negedge CLK);
            wr_acc = 1'b0;
            if ((mem_ren || mem_wen) && exp_addr_q.size() == 0) begin
                fail_run("memory request seen for a masked or finished lane");
            end else if (mem_ren || mem_wen) begin
                a    = exp_addr_q[0];
                lane = exp_lane_q[0];
                check("mem_addr", a, mem_addr);
                check("mem_ren", 32'(vmemdren), 32'(mem_ren));
                // byte enables select the element for loads and stores alike
                check("mem_be", 32'(lane_be(a, n)), 32'(mem_be));
                if (mem_wen) begin
                    check("mem_wdata", lane_wdata(vlane_store_data[lane], n), mem_wdata);
                end
                if (mem_ready) begin
                    if (mem_ren) begin
                        exp_load[lane] = sext_elem(mem[a[9:2]], a, n);
                    end else begin
                        wr_acc  = 1'b1;
                        wr_addr = a;
                        wr_old  = mem[a[9:2]];
                        wr_elem = vlane_store_data[lane];
                        wr_data = mem_wdata;
                        wr_be   = mem_be;
                    end
                    void'(exp_addr_q.pop_front());
                    void'(exp_lane_q.pop_front());
                end
            end
            done = ~stall;
            @(posedge CLK);
            #1;
            // memory takes the write through the DUT byte enables
            if (wr_acc) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_be[b]) mem[wr_addr[9:2]][8*b +: 8] = wr_data[8*b +: 8];
                end
                check("mem_word", merge_word(wr_old, wr_addr, wr_elem, n), mem[wr_addr[9:2]]);
            end
            mem_ready = ($urandom_range(0, 9) < 6);
            cyc++;
            if (!done && cyc == flush_at) begin
                flush    = 1'b1;
                vmemdren = 1'b0;
                vmemdwen = 1'b0;
                @(negedge CLK);
                check_quiet();
                @(posedge CLK);
                #1;
                flush      = 1'b0;
                model_next = '0;
                exp_addr_q.delete();
                exp_lane_q.delete();
                for (int i = 0; i < NUM_LANES; i++) begin
                    exp_load[i] = '0;
                end
                check_loads();
                flushed = 1'b1;
            end
        end
        if (!flushed && exp_addr_q.size() != 0) begin
            fail_run("micro-op ended before all active lanes were accessed");
        end else if (!flushed) begin
            check_loads();
        end
    endtask

    task automatic idle_cycle();
        vmemdren = 1'b0;
        vmemdwen = 1'b0;
        @(negedge CLK);
        check_quiet();
        @(posedge CLK);
        #1;
        mem_ready = ($urandom_range(0, 9) < 6);
    endtask

    initial begin
        int uops_left;
        int flush_at;
        bit flushed;
        void'($urandom(62704));
        nRST       = 1'b0;
        flush      = 1'b0;
        vmemdren   = 1'b0;
        vmemdwen   = 1'b0;
        vindexed   = 1'b0;
        base       = '0;
        stride     = '0;
        vuop_num   = 3'd0;
        veew       = SEW32;
        vlane_mask = 4'd0;
        mem_ready  = 1'b0;
        model_next = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            vlane_addr[i]       = '0;
            vlane_store_data[i] = '0;
            exp_load[i]         = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = $urandom;
        end
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        check_quiet();
        check_loads();
        @(posedge CLK);
        #1;
        uops_left = 0;
        for (int u = 0; u < NUM_UOPS; u++) begin
            if (uops_left == 0) begin
                new_instruction();
                uops_left = $urandom_range(1, 8);
            end else begin
                vuop_num = vuop_num + 3'd1;
            end
            issue_uop();
            flush_at = 0;
            if ($urandom_range(0, 19) == 0) flush_at = $urandom_range(1, 3);
            run_uop(flush_at, flushed);
            uops_left--;
            // a flushed instruction restarts from base
            if (flushed) uops_left = 0;
            else idle_cycle();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* files.f */
verilog/vmem_pkg.sv
verilog/vmem_coalescer.sv
verilog/vmem_store_format.sv
verilog/vmem_port_combine.sv
verilog/vmem_lsu_top.sv
sim/vmem_lsu_assert.sv
sim/vmem_lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module vmem_lsu_tb -f files.f -o vmem_lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/vmem_lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
